/* adc_display_assertions.sv */
// concurrent checks on the credit link and the I2C lines
// one instance sits in the sampler, one in the I2C master

module adc_display_assertions (
	input logic clk,
	input logic rst,
	input logic sample_vld,
	input logic credit,
	input logic rd_req,
	input logic busy,
	input logic scl,
	input logic sda,
	input logic start_stop
);

	// number of failed checks
	int err_count = 0;

	// a sample only leaves while the credit is held
	vld_needs_credit: assert property (
		@(posedge clk) disable iff (!rst) sample_vld |-> credit
	) else begin
		$error("sample_vld asserted without a credit");
		err_count++;
	end

	no_req_while_busy: assert property (
		@(posedge clk) disable iff (!rst) rd_req |-> !busy
	) else begin
		$error("rd_req asserted while the I2C master is busy");
		err_count++;
	end

	// data moves only while scl is low
	sda_stable_high: assert property (
		@(posedge clk) disable iff (!rst)
		(scl && $past(scl) && $changed(sda)) |-> start_stop
	) else begin
		$error("sda changed while scl was high outside START or STOP");
		err_count++;
	end

endmodule

// inputs that a target does not have are tied to inactive levels
bind adc_sampler adc_display_assertions i_sampler_checks (
	.clk(clk), .rst(rst), .sample_vld(sample_vld), .credit(credit),
	.rd_req(rd_req), .busy(busy), .scl(1'b0), .sda(1'b1), .start_stop(1'b0)
);

bind i2c_read_master adc_display_assertions i_bus_checks (
	.clk(clk), .rst(rst), .sample_vld(1'b0), .credit(1'b1),
	.rd_req(rd_req), .busy(busy), .scl(scl), .sda(sda_in),
	.start_stop(state == S_START || state == S_STOP)
);

/* adc_display_pkg.sv */
// shared types, segment codes and default timing for the ADC display
// imported by every block that carries samples or display digits

package adc_display_pkg;

	typedef logic [1:0] chan_t;

	typedef struct packed {
		chan_t       chan;
		logic [7:0]  value;
	} sample_t;

	typedef struct packed {
		logic        blank;
		logic [3:0]  bcd;
	} digit_t;

	// d3 is the channel digit, d2..d0 hundreds, tens, units
	typedef struct packed {
		digit_t d3;
		digit_t d2;
		digit_t d1;
		digit_t d0;
	} display_t;

	localparam logic [6:0] ADC_DEVICE_ID = 7'h54;

	// defaults for a 50 MHz board clock
	localparam logic [31:0] DEF_I2C_DIV    = 32'd125;
	localparam logic [31:0] DEF_SAMPLE_GAP = 32'd5_000_000;
	localparam logic [31:0] DEF_DEBOUNCE   = 32'd1_000_000;
	localparam logic [31:0] DEF_SCAN       = 32'd50_000;

	// active low, bit 7 is the decimal point and stays off
	function automatic logic [7:0] seg_code(digit_t d);
		logic [7:0] code;
		if (d.blank) begin
			code = 8'hff;
		end else begin
			case (d.bcd)
				4'd0:    code = 8'hc0;
				4'd1:    code = 8'hf9;
				4'd2:    code = 8'ha4;
				4'd3:    code = 8'hb0;
				4'd4:    code = 8'h99;
				4'd5:    code = 8'h92;
				4'd6:    code = 8'h82;
				4'd7:    code = 8'hf8;
				4'd8:    code = 8'h80;
				4'd9:    code = 8'h90;
				default: code = 8'hff;
			endcase
		end
		return code;
	endfunction

endpackage

/* adc_display_testdata.txt */
0 0 07 2a 80 ff c0 ff ff f8
1 0 07 2a 80 ff f9 ff 99 a4
1 0 07 2a 80 ff a4 f9 a4 80
1 0 07 2a 80 ff b0 a4 92 92
1 0 07 2a 80 ff c0 ff ff f8
0 1 07 2a 80 ff c0 ff ff f8
0 0 00 2a 80 ff c0 ff ff c0
0 0 63 2a 80 ff c0 ff 90 90
2 0 63 2a 64 ff a4 f9 c0 c0
0 0 63 2a 0a ff a4 ff f9 c0
3 0 63 c8 0a ff f9 a4 c0 c0
1 0 63 c8 f5 ff a4 a4 99 92

/* adc_display_top.sv */
// ADC reader with seven-segment output: key selects the channel,
// the sampled value is shown in decimal next to the channel digit

module adc_display_top #(
	parameter logic [31:0] I2C_DIV    = adc_display_pkg::DEF_I2C_DIV,
	parameter logic [31:0] SAMPLE_GAP = adc_display_pkg::DEF_SAMPLE_GAP,
	parameter logic [31:0] DEBOUNCE   = adc_display_pkg::DEF_DEBOUNCE,
	parameter logic [31:0] SCAN       = adc_display_pkg::DEF_SCAN
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       key,
	output logic [3:0] led,
	output logic [7:0] seg,
	output logic [3:0] dig,
	output logic       scl,
	inout  wire        sda
);
	import adc_display_pkg::*;

	logic       press;
	logic       rd_req;
	logic [7:0] ctrl_byte;
	logic [7:0] rd_data;
	logic       rd_vld;
	logic       ack_err;
	logic       busy;
	sample_t    sample;
	logic       sample_vld;
	logic       credit_ret;
	display_t   disp;
	logic       sda_oe;
	logic       sda_in;

	// open drain, pull-up is on the board
	assign sda    = sda_oe ? 1'b0 : 1'bz;
	assign sda_in = sda;

	key_debounce #(.DEBOUNCE(DEBOUNCE)) i_key_debounce (
		.clk(clk), .rst(rst), .key(key), .press(press)
	);

	adc_sampler #(.SAMPLE_GAP(SAMPLE_GAP)) i_adc_sampler (
		.clk(clk), .rst(rst), .press(press),
		.rd_req(rd_req), .ctrl_byte(ctrl_byte), .rd_data(rd_data),
		.rd_vld(rd_vld), .ack_err(ack_err), .busy(busy),
		.sample(sample), .sample_vld(sample_vld), .credit_ret(credit_ret),
		.led(led)
	);

	i2c_read_master #(.I2C_DIV(I2C_DIV)) i_i2c_read_master (
		.clk(clk), .rst(rst), .rd_req(rd_req), .ctrl_byte(ctrl_byte),
		.rd_data(rd_data), .rd_vld(rd_vld), .ack_err(ack_err), .busy(busy),
		.scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
	);

	bin_to_bcd i_bin_to_bcd (
		.clk(clk), .rst(rst), .sample(sample), .sample_vld(sample_vld),
		.credit_ret(credit_ret), .disp(disp)
	);

	seg_scan #(.SCAN(SCAN)) i_seg_scan (
		.clk(clk), .rst(rst), .disp(disp), .seg(seg), .dig(dig)
	);

endmodule

/* adc_sampler.sv */
// channel register, gap timer and credit holder between the I2C master
// and the decimal converter; each read starts only while the credit is held

module adc_sampler #(
	parameter logic [31:0] SAMPLE_GAP = adc_display_pkg::DEF_SAMPLE_GAP
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     press,
	output logic                     rd_req,
	output logic [7:0]               ctrl_byte,
	input  logic [7:0]               rd_data,
	input  logic                     rd_vld,
	input  logic                     ack_err,
	input  logic                     busy,
	output adc_display_pkg::sample_t sample,
	output logic                     sample_vld,
	input  logic                     credit_ret,
	output logic [3:0]               led
);
	import adc_display_pkg::*;

	chan_t       chan;
	chan_t       req_chan;
	logic        credit;
	logic        in_flight;
	logic [31:0] gap_cnt;

	// req_chan is the channel of the read in progress, not the live one
	assign ctrl_byte = {6'b01_0000, req_chan};
	assign led       = 4'b0001 << chan;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			chan       <= '0;
			req_chan   <= '0;
			credit     <= 1'b1;
			in_flight  <= 1'b0;
			gap_cnt    <= '0;
			rd_req     <= 1'b0;
			sample_vld <= 1'b0;
			sample     <= '0;
		end else begin
			rd_req     <= 1'b0;
			sample_vld <= rd_vld;
			if (press)
				chan <= chan + 1'b1;
			if (rd_vld)
				sample <= '{chan: req_chan, value: rd_data};
			if (credit_ret)
				credit <= 1'b1;
			else if (sample_vld)
				credit <= 1'b0;
			// gap restarts when the read ends, good or not
			if (rd_vld || ack_err) begin
				in_flight <= 1'b0;
				gap_cnt   <= '0;
			end else if (!in_flight) begin
				if (gap_cnt < SAMPLE_GAP) begin
					gap_cnt <= gap_cnt + 1'b1;
				end else if (credit && !busy) begin
					rd_req    <= 1'b1;
					in_flight <= 1'b1;
					req_chan  <= chan;
				end
			end
		end
	end

endmodule

/* bin_to_bcd.sv */
// shift-and-add-3 conversion of one sample to three decimal digits
// leading zeros are blanked, result lands in disp together with credit_ret

module bin_to_bcd (
	input  logic                      clk,
	input  logic                      rst,
	input  adc_display_pkg::sample_t  sample,
	input  logic                      sample_vld,
	output logic                      credit_ret,
	output adc_display_pkg::display_t disp
);
	import adc_display_pkg::*;

	logic [19:0] work;
	chan_t       chan_q;
	logic [3:0]  step;
	logic        run;

	// add 3 to every digit above 4, then shift the whole word left
	function automatic logic [19:0] dabble(logic [19:0] w);
		logic [19:0] t;
		t = w;
		if (t[11:8] >= 4'd5)
			t[11:8] = t[11:8] + 4'd3;
		if (t[15:12] >= 4'd5)
			t[15:12] = t[15:12] + 4'd3;
		if (t[19:16] >= 4'd5)
			t[19:16] = t[19:16] + 4'd3;
		return {t[18:0], 1'b0};
	endfunction

	always_ff @(posedge clk) begin
		if (sample_vld) begin
			work   <= {12'd0, sample.value};
			chan_q <= sample.chan;
		end else if (run && step != 4'd8) begin
			work <= dabble(work);
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			run        <= 1'b0;
			step       <= '0;
			credit_ret <= 1'b0;
			disp       <= '{default: '{blank: 1'b1, bcd: 4'd0}};
		end else begin
			credit_ret <= 1'b0;
			if (sample_vld) begin
				run  <= 1'b1;
				step <= '0;
			end else if (run) begin
				if (step == 4'd8) begin
					run        <= 1'b0;
					credit_ret <= 1'b1;
					disp.d3    <= '{blank: 1'b0, bcd: {2'b00, chan_q}};
					disp.d2    <= '{blank: work[19:16] == 4'd0, bcd: work[19:16]};
					disp.d1    <= '{blank: work[19:12] == 8'd0, bcd: work[15:12]};
					disp.d0    <= '{blank: 1'b0, bcd: work[11:8]};
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

endmodule

/* i2c_read_master.sv */
// I2C master for the ADC: one combined transaction per rd_req
// START, addr+W, control byte, repeated START, addr+R, data byte with NACK, STOP
// every bit is split into four quarter ticks of I2C_DIV clocks

module i2c_read_master #(
	parameter logic [31:0] I2C_DIV = adc_display_pkg::DEF_I2C_DIV
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        rd_req,
	input  logic [7:0]  ctrl_byte,
	output logic [7:0]  rd_data,
	output logic        rd_vld,
	output logic        ack_err,
	output logic        busy,
	output logic        scl,
	output logic        sda_oe,
	input  logic        sda_in
);
	import adc_display_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_START, S_BYTE, S_STOP} state_t;

	state_t      state;
	logic [31:0] div_cnt;
	logic        qtick;
	logic [1:0]  phase;
	logic [3:0]  bit_cnt;
	logic [1:0]  byte_idx;
	logic [7:0]  shreg;
	logic [7:0]  ctrl_q;
	logic        nack;
	logic        reading;

	assign busy    = (state != S_IDLE);
	assign qtick   = busy && (div_cnt == I2C_DIV - 1);
	// byte 3 is the data byte coming back from the converter
	assign reading = (byte_idx == 2'd3);
	assign rd_data = shreg;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			div_cnt <= '0;
		else if (!busy || qtick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= S_IDLE;
			phase    <= '0;
			bit_cnt  <= '0;
			byte_idx <= '0;
			shreg    <= '0;
			ctrl_q   <= '0;
			nack     <= 1'b0;
			scl      <= 1'b1;
			sda_oe   <= 1'b0;
			rd_vld   <= 1'b0;
			ack_err  <= 1'b0;
		end else begin
			rd_vld  <= 1'b0;
			ack_err <= 1'b0;
			case (state)
				S_IDLE: begin
					phase <= '0;
					if (rd_req) begin
						state    <= S_START;
						byte_idx <= '0;
						nack     <= 1'b0;
						ctrl_q   <= ctrl_byte;
						shreg    <= {ADC_DEVICE_ID, 1'b0};
					end
				end
				// also used for the repeated start, where scl enters low
				S_START: if (qtick) begin
					phase <= phase + 1'b1;
					case (phase)
						2'd0: sda_oe <= 1'b0;
						2'd1: scl <= 1'b1;
						2'd2: sda_oe <= 1'b1;
						default: begin
							scl     <= 1'b0;
							bit_cnt <= '0;
							state   <= S_BYTE;
						end
					endcase
				end
				S_BYTE: if (qtick) begin
					phase <= phase + 1'b1;
					case (phase)
						2'd0: sda_oe <= (bit_cnt != 4'd8 && !reading) ? ~shreg[7] : 1'b0;
						2'd1: scl <= 1'b1;
						2'd2: begin
							if (bit_cnt == 4'd8) begin
								if (!reading)
									nack <= sda_in;
							end else if (reading) begin
								shreg <= {shreg[6:0], sda_in};
							end
						end
						default: begin
							scl <= 1'b0;
							if (bit_cnt != 4'd8) begin
								bit_cnt <= bit_cnt + 1'b1;
								if (!reading)
									shreg <= {shreg[6:0], 1'b0};
							end else begin
								bit_cnt <= '0;
								if (nack || reading) begin
									state <= S_STOP;
								end else begin
									byte_idx <= byte_idx + 1'b1;
									if (byte_idx == 2'd0) begin
										shreg <= ctrl_q;
									end else if (byte_idx == 2'd1) begin
										shreg <= {ADC_DEVICE_ID, 1'b1};
										state <= S_START;
									end
								end
							end
						end
					endcase
				end
				S_STOP: if (qtick) begin
					phase <= phase + 1'b1;
					case (phase)
						2'd0: sda_oe <= 1'b1;
						2'd1: scl <= 1'b1;
						2'd2: sda_oe <= 1'b0;
						default: begin
							state   <= S_IDLE;
							rd_vld  <= !nack;
							ack_err <= nack;
						end
					endcase
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* key_debounce.sv */
// debounce for the active-low channel key
// press pulses once when the key has been stably low for DEBOUNCE cycles

module key_debounce #(
	parameter logic [31:0] DEBOUNCE = adc_display_pkg::DEF_DEBOUNCE
) (
	input  logic clk,
	input  logic rst,
	input  logic key,
	output logic press
);

	logic [1:0]  sync;
	logic        key_s;
	logic        state;
	logic [31:0] cnt;

	assign key_s = sync[1];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sync  <= 2'b11;
			state <= 1'b1;
			cnt   <= '0;
			press <= 1'b0;
		end else begin
			sync  <= {sync[0], key};
			press <= 1'b0;
			if (key_s == state) begin
				cnt <= '0;
			end else if (cnt == DEBOUNCE - 1) begin
				// new level has held long enough
				cnt   <= '0;
				state <= key_s;
				press <= !key_s;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

/* seg_scan.sv */
// four-digit multiplexer with active-low digit select and segments
// the digit is latched at the start of its slot, so a new disp shows next slot

module seg_scan #(
	parameter logic [31:0] SCAN = adc_display_pkg::DEF_SCAN
) (
	input  logic                      clk,
	input  logic                      rst,
	input  adc_display_pkg::display_t disp,
	output logic [7:0]                seg,
	output logic [3:0]                dig
);
	import adc_display_pkg::*;

	logic [31:0] slot_cnt;
	logic [1:0]  idx;
	logic        slot_end;

	function automatic digit_t pick(display_t d, logic [1:0] i);
		digit_t r;
		case (i)
			2'd0:    r = d.d0;
			2'd1:    r = d.d1;
			2'd2:    r = d.d2;
			default: r = d.d3;
		endcase
		return r;
	endfunction

	assign slot_end = (slot_cnt == SCAN - 1);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			slot_cnt <= '0;
		else if (slot_end)
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	// all digits stay off until the first slot begins
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			idx <= '0;
			dig <= 4'b1111;
			seg <= 8'hff;
		end else if (slot_end) begin
			idx <= idx + 1'b1;
			dig <= ~(4'b0001 << idx);
			seg <= seg_code(pick(disp, idx));
		end
	end

endmodule

/* tb_adc_display.sv */
// testbench for adc_display_top with an I2C converter model on the bus
// each line of the test data file sets the model's samples and key actions,
// then the scanned display, the LEDs and the last control byte are checked

module tb_adc_display;
	import adc_display_pkg::*;

	localparam int CLK_PERIOD  = 10;
	localparam int I2C_DIV     = 2;
	localparam int SAMPLE_GAP  = 20;
	localparam int DEBOUNCE    = 8;
	localparam int SCAN        = 4;
	localparam int POLL_LIMIT  = 2000;
	localparam int TEST_CYCLES = 4000;

	logic       clk = 1'b0;
	logic       rst;
	logic       key;
	logic [3:0] led;
	logic [7:0] seg;
	logic [3:0] dig;
	wire        scl;
	tri1        sda;

	// converter model
	logic [7:0] chan_val [0:3];
	logic [7:0] last_ctrl = 8'h00;
	logic [7:0] sh = 8'h00;
	logic [7:0] tx = 8'h00;
	int         bcnt = 0;
	logic       addr_phase = 1'b1;
	logic       sel = 1'b0;
	logic       rd = 1'b0;
	logic       start_tx = 1'b0;
	logic       sending = 1'b0;
	logic       slave_low = 1'b0;

	// test table and display capture
	int          t_presses [$];
	int          t_bounce [$];
	logic [31:0] t_vals [$];
	logic [31:0] t_exp [$];
	int          n_tests = 0;
	bit          loaded = 1'b0;
	int          pass_count = 0;
	int          fail_count = 0;
	logic [31:0] shown = '1;
	logic [3:0]  seen = '0;

	adc_display_top #(
		.I2C_DIV(I2C_DIV),
		.SAMPLE_GAP(SAMPLE_GAP),
		.DEBOUNCE(DEBOUNCE),
		.SCAN(SCAN)
	) i_dut (
		.clk(clk), .rst(rst), .key(key), .led(led),
		.seg(seg), .dig(dig), .scl(scl), .sda(sda)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	assign sda = slave_low ? 1'b0 : 1'bz;

	// START and STOP, sda moving while scl is high
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			bcnt       = 0;
			addr_phase = 1'b1;
			sel        = 1'b0;
			start_tx   = 1'b0;
			sending    = 1'b0;
			slave_low  = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin
			bcnt       = 0;
			addr_phase = 1'b1;
			sending    = 1'b0;
		end
	end

	// bits 1..8 are data, bit 9 is the acknowledge
	always @(posedge scl) begin
		if (bcnt < 9)
			bcnt = bcnt + 1;
		if (bcnt <= 8 && !sending)
			sh = {sh[6:0], sda};
	end

	always @(negedge scl) begin
		if (bcnt == 8) begin
			if (sending) begin
				// master answers the data byte itself
				slave_low = 1'b0;
			end else if (addr_phase) begin
				sel        = (sh[7:1] == ADC_DEVICE_ID);
				rd         = sh[0];
				addr_phase = 1'b0;
				start_tx   = sel && rd;
				slave_low  = sel;
			end else begin
				if (sel)
					last_ctrl = sh;
				slave_low = sel;
			end
		end else if (bcnt == 9) begin
			bcnt      = 0;
			slave_low = 1'b0;
			if (sending) begin
				sending = 1'b0;
			end else if (start_tx) begin
				start_tx  = 1'b0;
				sending   = 1'b1;
				tx        = chan_val[last_ctrl[1:0]];
				slave_low = !tx[7];
			end
		end else if (sending && bcnt >= 1) begin
			slave_low = !tx[7 - bcnt];
		end
	end

	// grab the segments of whichever digit is selected
	always @(negedge clk) begin
		for (int p = 0; p < 4; p++) begin
			if (dig == ~(4'b0001 << p)) begin
				shown[p*8 +: 8] <= seg;
				seen[p]         <= 1'b1;
			end
		end
	end

	task automatic pulse_key(input int low_cycles);
		@(posedge clk);
		#1 key = 1'b0;
		repeat (low_cycles) @(posedge clk);
		#1 key = 1'b1;
		repeat (3 * DEBOUNCE) @(posedge clk);
	endtask

	task automatic wait_display(input logic [31:0] exp, output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < POLL_LIMIT) begin
			@(negedge clk);
			if (shown == exp)
				ok = 1'b1;
			n++;
		end
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			pass_count++;
			$display("%s passed", name);
		end else begin
			fail_count++;
			$display("%s failed with %0d errors", name, errs);
		end
	endtask

	initial begin
		wait (loaded);
		#((n_tests + 1) * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog timeout, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int         fd;
		int         r;
		int         presses;
		int         bounce;
		int         errs;
		int         assert_errs;
		logic [7:0] s [0:3];
		logic [7:0] e [0:3];
		logic [1:0] chan_exp;
		bit         ok;

		rst      = 1'b0;
		key      = 1'b1;
		chan_exp = 2'd0;
		for (int c = 0; c < 4; c++)
			chan_val[c] = 8'h00;

		fd = $fopen("adc_display_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			$display("Simulation failed");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				r = $fscanf(fd, "%d %d %h %h %h %h %h %h %h %h", presses, bounce,
					s[0], s[1], s[2], s[3], e[0], e[1], e[2], e[3]);
				if (r == 10) begin
					t_presses.push_back(presses);
					t_bounce.push_back(bounce);
					t_vals.push_back({s[3], s[2], s[1], s[0]});
					// file lists digit 3 first
					t_exp.push_back({e[0], e[1], e[2], e[3]});
					n_tests++;
				end
			end
			$fclose(fd);
			loaded = 1'b1;

			repeat (16) @(posedge clk);
			#1 rst = 1'b1;

			// blank display until the first sample lands
			errs = 0;
			seen = '0;
			r    = 0;
			while (seen != 4'hf && r < 100) begin
				@(negedge clk);
				r++;
			end
			if (seen != 4'hf) begin
				$display("reset test: the display never scanned all four digits");
				errs++;
			end else if (shown != 32'hffff_ffff) begin
				$display("error at %0t: display %h after reset, expected all blank",
					$time, shown);
				errs++;
			end
			if (led !== 4'b0001) begin
				$display("error at %0t: led %b after reset, expected 0001", $time, led);
				errs++;
			end
			report_test("reset test", errs);

			for (int t = 0; t < n_tests; t++) begin
				errs = 0;
				for (int c = 0; c < 4; c++)
					chan_val[c] = t_vals[t][c*8 +: 8];
				if (t_bounce[t] != 0)
					pulse_key(DEBOUNCE / 2);
				repeat (t_presses[t])
					pulse_key(3 * DEBOUNCE);
				chan_exp = chan_exp + t_presses[t][1:0];
				wait_display(t_exp[t], ok);
				if (!ok) begin
					$display("error at %0t: test %0d display %h, expected %h",
						$time, t + 1, shown, t_exp[t]);
					errs++;
				end
				if (led !== (4'b0001 << chan_exp)) begin
					$display("error at %0t: test %0d led %b, expected channel %0d",
						$time, t + 1, led, chan_exp);
					errs++;
				end
				if (last_ctrl !== (8'h40 | chan_exp)) begin
					$display("error at %0t: test %0d control byte %h, expected %h",
						$time, t + 1, last_ctrl, 8'h40 | chan_exp);
					errs++;
				end
				report_test($sformatf("test %0d", t + 1), errs);
			end

			assert_errs = i_dut.i_adc_sampler.i_sampler_checks.err_count
				+ i_dut.i_i2c_read_master.i_bus_checks.err_count;
			if (assert_errs != 0)
				$display("bound assertions failed %0d times", assert_errs);
			$display("tests passed %0d, failed %0d", pass_count, fail_count);
			if (fail_count == 0 && assert_errs == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

/* verilog.f */
adc_display_pkg.sv
key_debounce.sv
adc_sampler.sv
i2c_read_master.sv
bin_to_bcd.sv
seg_scan.sv
adc_display_top.sv
adc_display_assertions.sv
tb_adc_display.sv
